//--- rtl/pm_pkg.sv
package pm_pkg;

	// data path widths
	localparam int img_ww  = 12;
	localparam int step_w  = 32;
	localparam int speed_w = 32;
	localparam int frm_w   = 2;
	localparam int tbl_aw  = 8;
	localparam int cfg_dw  = 32;

	// image coordinate below destination means move forward
	localparam bit img_l2r = 1'b1;

	typedef logic [img_ww-1:0]         img_pos_t;
	typedef logic signed [step_w-1:0]  step_t;
	typedef logic [speed_w-1:0]        speed_t;
	typedef logic [frm_w-1:0]          frm_t;
	typedef logic [tbl_aw-1:0]         tbl_addr_t;
	typedef logic [3:0]                reg_addr_t;

	// register map
	localparam reg_addr_t reg_ctl      = 4'd0;
	localparam reg_addr_t reg_dst      = 4'd1;
	localparam reg_addr_t reg_tol      = 4'd2;
	localparam reg_addr_t reg_speed    = 4'd3;
	localparam reg_addr_t reg_step     = 4'd4;
	localparam reg_addr_t reg_frm      = 4'd5;
	localparam reg_addr_t reg_tbl_ptr  = 4'd8;
	localparam reg_addr_t reg_tbl_data = 4'd9;

	// bit positions in the control register
	localparam int ctl_run_bit    = 0;
	localparam int ctl_single_bit = 1;
	localparam int ctl_abs_bit    = 2;
	localparam int ctl_img_bit    = 3;

	typedef struct packed {
		logic     run;
		logic     single_dir;
		logic     abs;
		logic     dep_img;
		img_pos_t img_dst;
		img_pos_t img_tol;
		speed_t   speed;
		step_t    step;
		frm_t     delay_frm;
	} pm_req_t;

	typedef struct packed {
		speed_t speed;
		step_t  step;
		logic   abs;
	} pm_cmd_t;

endpackage

//--- rtl/pm_regs.sv
`timescale 1ns/1ps

module pm_regs (
	input  logic                       clk,
	input  logic                       resetn,
	input  logic                       cfg_wr,
	input  pm_pkg::reg_addr_t          cfg_addr,
	input  logic [pm_pkg::cfg_dw-1:0]  cfg_wdata,
	output pm_pkg::pm_req_t            req,
	output logic                       tbl_we,
	output pm_pkg::tbl_addr_t          tbl_waddr,
	output pm_pkg::step_t              tbl_wdata
);
	import pm_pkg::*;

	tbl_addr_t tbl_ptr;

	// settings registers and table pointer
	always_ff @(posedge clk) begin
		if (!resetn) begin
			req     <= '0;
			tbl_ptr <= '0;
		end else if (cfg_wr) begin
			case (cfg_addr)
				reg_ctl: begin
					req.run        <= cfg_wdata[ctl_run_bit];
					req.single_dir <= cfg_wdata[ctl_single_bit];
					req.abs        <= cfg_wdata[ctl_abs_bit];
					req.dep_img    <= cfg_wdata[ctl_img_bit];
				end
				reg_dst:      req.img_dst   <= cfg_wdata[img_ww-1:0];
				reg_tol:      req.img_tol   <= cfg_wdata[img_ww-1:0];
				reg_speed:    req.speed     <= cfg_wdata[speed_w-1:0];
				reg_step:     req.step      <= cfg_wdata[step_w-1:0];
				reg_frm:      req.delay_frm <= cfg_wdata[frm_w-1:0];
				reg_tbl_ptr:  tbl_ptr       <= cfg_wdata[tbl_aw-1:0];
				// pointer moves on after each data write
				reg_tbl_data: tbl_ptr       <= tbl_ptr + 1'b1;
				default: ;
			endcase
		end
	end

	// one-cycle table write strobe
	always_ff @(posedge clk) begin
		if (!resetn)
			tbl_we <= 1'b0;
		else
			tbl_we <= cfg_wr && (cfg_addr == reg_tbl_data);
	end

	always_ff @(posedge clk) begin
		tbl_waddr <= tbl_ptr;
		tbl_wdata <= cfg_wdata[step_w-1:0];
	end

endmodule

//--- rtl/pos_delay.sv
`timescale 1ns/1ps

module pos_delay (
	input  logic          clk,
	input  logic          resetn,
	input  logic          eof,
	input  pm_pkg::frm_t  delay_frm,
	input  pm_pkg::step_t cur_pos,
	output pm_pkg::step_t movie_pos
);
	import pm_pkg::*;

	localparam int depth = 2 ** frm_w;

	step_t hist [depth];

	// newest sample at index 0
	always_ff @(posedge clk) begin
		if (!resetn) begin
			for (int i = 0; i < depth; i++)
				hist[i] <= '0;
		end else if (eof) begin
			hist[0] <= cur_pos;
			for (int i = 1; i < depth; i++)
				hist[i] <= hist[i-1];
		end
	end

	// position as it was delay_frm frames back
	always_ff @(posedge clk) begin
		if (!resetn)
			movie_pos <= '0;
		else
			movie_pos <= hist[delay_frm];
	end

endmodule

//--- rtl/step_table.sv
`timescale 1ns/1ps

module step_table (
	input  logic              clk,
	input  logic              we,
	input  pm_pkg::tbl_addr_t waddr,
	input  pm_pkg::step_t     wdata,
	input  pm_pkg::tbl_addr_t raddr,
	output pm_pkg::step_t     rdata
);
	import pm_pkg::*;

	localparam int entries = 2 ** tbl_aw;

	// pixel error magnitude to step count
	step_t mem [entries];

	always_ff @(posedge clk) begin
		if (we)
			mem[waddr] <= wdata;
	end

	// registered read, data one clock after address
	always_ff @(posedge clk) begin
		rdata <= mem[raddr];
	end

endmodule

//--- rtl/pm_ctl.sv
`timescale 1ns/1ps

module pm_ctl (
	input  logic              clk,
	input  logic              resetn,
	input  pm_pkg::pm_req_t   req,
	input  logic              img_pulse,
	input  logic              img_valid,
	input  pm_pkg::img_pos_t  img_pos,
	input  logic              m_state,
	input  pm_pkg::step_t     m_position,
	input  pm_pkg::step_t     movie_pos,
	input  pm_pkg::step_t     rd_data,
	output pm_pkg::tbl_addr_t rd_addr,
	output logic              m_start,
	output pm_pkg::pm_cmd_t   m_cmd,
	output logic              m_stop,
	output logic              m_mod_remain,
	output pm_pkg::step_t     m_new_remain,
	output logic              exe_done
);
	import pm_pkg::*;

	logic     img_pen;
	img_pos_t frm_pos, frm_dst, frm_tol;
	logic     pen_d1, pen_d2, pen_d3, pen_d4, pen_d5;
	img_pos_t pos_l, pos_d, pos_r, pos_c;
	logic     pos_lofl, pos_rofr, pos_lofd;
	img_pos_t pos_dmc, pos_cmd;
	logic     pos_ok, need_back;
	logic     pos_ok_d4, need_back_d4;
	logic     pos_ok_d5, pos_over;
	step_t    dst_pos, step_d5;
	logic     m_started, m_run_over, need_dyn_adjust;
	logic     dir_back, m_stopped;

	assign dir_back  = req.step[step_w-1];
	assign m_stopped = m_run_over && !m_state;

	// enable chain, one bit per stage
	always_ff @(posedge clk) begin
		if (!resetn)
			{img_pen, pen_d1, pen_d2, pen_d3, pen_d4, pen_d5} <= '0;
		else
			{img_pen, pen_d1, pen_d2, pen_d3, pen_d4, pen_d5} <=
				{img_pulse && req.dep_img, img_pen, pen_d1, pen_d2, pen_d3, pen_d4};
	end

	// frame inputs sampled at the frame edge
	always_ff @(posedge clk) begin
		if (img_pulse) begin
			frm_pos <= img_pos;
			frm_dst <= req.img_dst;
			frm_tol <= req.img_tol;
		end
	end

	// stage 1: window edges and measured position
	always_ff @(posedge clk) begin
		if (img_pen) begin
			pos_l <= frm_dst - frm_tol;
			pos_d <= frm_dst;
			pos_r <= frm_dst + frm_tol;
			pos_c <= frm_pos;
		end
	end

	// stage 2: compare against window
	always_ff @(posedge clk) begin
		if (pen_d1) begin
			pos_lofl <= pos_c < pos_l;
			pos_rofr <= pos_c > pos_r;
			pos_lofd <= pos_c < pos_d;
			pos_dmc  <= pos_d - pos_c;
			pos_cmd  <= pos_c - pos_d;
		end
	end

	// stage 3: decision and table address
	always_ff @(posedge clk) begin
		if (!resetn) begin
			pos_ok    <= 1'b0;
			need_back <= 1'b0;
			rd_addr   <= '0;
		end else if (pen_d2) begin
			pos_ok    <= !pos_rofr && !pos_lofl;
			need_back <= (pos_lofd != img_l2r);
			// pixel error truncated to the table index
			if (pos_rofr)
				rd_addr <= pos_cmd[tbl_aw-1:0];
			else if (pos_lofl)
				rd_addr <= pos_dmc[tbl_aw-1:0];
			else
				rd_addr <= '0;
		end
	end

	// stage 4
	always_ff @(posedge clk) begin
		if (!resetn) begin
			pos_ok_d4    <= 1'b0;
			need_back_d4 <= 1'b0;
		end else if (pen_d3) begin
			pos_ok_d4    <= pos_ok;
			need_back_d4 <= need_back;
		end
	end

	// stage 5: overshoot and target motor position
	always_ff @(posedge clk) begin
		if (!resetn) begin
			pos_ok_d5 <= 1'b0;
			pos_over  <= 1'b0;
		end else if (pen_d4) begin
			pos_ok_d5 <= pos_ok_d4;
			pos_over  <= !pos_ok_d4 && (need_back_d4 != dir_back);
		end
	end

	always_ff @(posedge clk) begin
		if (pen_d4) begin
			step_d5 <= rd_data;
			dst_pos <= need_back_d4 ? movie_pos - rd_data : movie_pos + rd_data;
		end
	end

	// motor run history
	always_ff @(posedge clk) begin
		if (!resetn) begin
			m_started  <= 1'b0;
			m_run_over <= 1'b0;
		end else begin
			if (m_start)
				m_started <= 1'b1;
			if (m_state)
				m_run_over <= 1'b1;
		end
	end

	// early stop not implemented, held low
	assign m_stop = 1'b0;

	// start command, image or direct
	always_ff @(posedge clk) begin
		if (!resetn) begin
			m_start         <= 1'b0;
			m_cmd           <= '0;
			need_dyn_adjust <= 1'b0;
		end else if (m_start) begin
			m_start <= 1'b0;
		end else if (req.dep_img) begin
			if (pen_d5 && req.single_dir && !pos_ok_d5 && !pos_over && !m_started) begin
				m_start     <= 1'b1;
				m_cmd.speed <= req.speed;
				m_cmd.step  <= img_valid ? step_d5 : '0;
				m_cmd.abs   <= 1'b0;
				// zero-step move is steered by later frames
				if (!img_valid)
					need_dyn_adjust <= 1'b1;
			end
		end else if (req.run && !m_started) begin
			m_start     <= 1'b1;
			m_cmd.speed <= req.speed;
			m_cmd.step  <= req.step;
			m_cmd.abs   <= req.abs;
		end
	end

	// remaining step correction while running
	always_ff @(posedge clk) begin
		if (!resetn) begin
			m_mod_remain <= 1'b0;
			m_new_remain <= '0;
		end else if (m_mod_remain) begin
			m_mod_remain <= 1'b0;
		end else if (pen_d5 && req.single_dir && m_state && need_dyn_adjust && img_valid) begin
			if (dir_back && m_position > dst_pos) begin
				m_mod_remain <= 1'b1;
				m_new_remain <= m_position - dst_pos;
			end else if (!dir_back && m_position < dst_pos) begin
				m_mod_remain <= 1'b1;
				m_new_remain <= dst_pos - m_position;
			end
		end
	end

	// sticky done flag
	always_ff @(posedge clk) begin
		if (!resetn)
			exe_done <= 1'b0;
		else if (req.single_dir && (m_stopped || pos_over))
			exe_done <= 1'b1;
	end

endmodule

//--- rtl/pm_top.sv
`timescale 1ns/1ps

module pm_top (
	input  logic                       clk,
	input  logic                       resetn,
	input  logic                       cfg_wr,
	input  pm_pkg::reg_addr_t          cfg_addr,
	input  logic [pm_pkg::cfg_dw-1:0]  cfg_wdata,
	input  logic                       img_pulse,
	input  logic                       img_valid,
	input  pm_pkg::img_pos_t           img_pos,
	input  logic                       m_state,
	input  pm_pkg::step_t              m_position,
	output logic                       m_start,
	output pm_pkg::pm_cmd_t            m_cmd,
	output logic                       m_stop,
	output logic                       m_mod_remain,
	output pm_pkg::step_t              m_new_remain,
	output logic                       exe_done
);
	import pm_pkg::*;

	pm_req_t   req;
	logic      tbl_we;
	tbl_addr_t tbl_waddr;
	step_t     tbl_wdata;
	tbl_addr_t rd_addr;
	step_t     rd_data;
	step_t     movie_pos;

	pm_regs u_pm_regs (
		.clk       (clk),
		.resetn    (resetn),
		.cfg_wr    (cfg_wr),
		.cfg_addr  (cfg_addr),
		.cfg_wdata (cfg_wdata),
		.req       (req),
		.tbl_we    (tbl_we),
		.tbl_waddr (tbl_waddr),
		.tbl_wdata (tbl_wdata)
	);

	// motor position aligned to image latency
	pos_delay u_pos_delay (
		.clk       (clk),
		.resetn    (resetn),
		.eof       (img_pulse),
		.delay_frm (req.delay_frm),
		.cur_pos   (m_position),
		.movie_pos (movie_pos)
	);

	step_table u_step_table (
		.clk   (clk),
		.we    (tbl_we),
		.waddr (tbl_waddr),
		.wdata (tbl_wdata),
		.raddr (rd_addr),
		.rdata (rd_data)
	);

	pm_ctl u_pm_ctl (
		.clk          (clk),
		.resetn       (resetn),
		.req          (req),
		.img_pulse    (img_pulse),
		.img_valid    (img_valid),
		.img_pos      (img_pos),
		.m_state      (m_state),
		.m_position   (m_position),
		.movie_pos    (movie_pos),
		.rd_data      (rd_data),
		.rd_addr      (rd_addr),
		.m_start      (m_start),
		.m_cmd        (m_cmd),
		.m_stop       (m_stop),
		.m_mod_remain (m_mod_remain),
		.m_new_remain (m_new_remain),
		.exe_done     (exe_done)
	);

endmodule

//--- bench/pm_tb_assert.sv
`timescale 1ns/1ps

module pm_ctl_assert (
	input logic       clk,
	input logic       resetn,
	input logic       m_start,
	input logic       m_stop,
	input logic       m_mod_remain,
	input logic       exe_done,
	input logic [4:0] pen
);
	logic start_seen;
	// failed assertion count
	int   n_fail = 0;

	// remembers a start since the last reset
	always_ff @(posedge clk) begin
		if (!resetn)
			start_seen <= 1'b0;
		else if (m_start)
			start_seen <= 1'b1;
	end

	a_start_pulse: assert property (@(posedge clk) disable iff (!resetn) m_start |=> !m_start)
		else begin
			$error("m_start high for two cycles");
			n_fail++;
		end

	a_stop_pulse: assert property (@(posedge clk) disable iff (!resetn) m_stop |=> !m_stop)
		else begin
			$error("m_stop high for two cycles");
			n_fail++;
		end

	a_mod_pulse: assert property (@(posedge clk) disable iff (!resetn)
		m_mod_remain |=> !m_mod_remain)
		else begin
			$error("m_mod_remain high for two cycles");
			n_fail++;
		end

	// everything quiet once reset has been applied
	a_reset_state: assert property (@(posedge clk)
		!resetn |=> !m_start && !m_stop && !m_mod_remain && !exe_done && pen == '0)
		else begin
			$error("controller outputs not low after reset");
			n_fail++;
		end

	a_one_start: assert property (@(posedge clk) disable iff (!resetn) m_start |-> !start_seen)
		else begin
			$error("second m_start within one reset");
			n_fail++;
		end

endmodule

bind pm_ctl pm_ctl_assert u_pm_ctl_assert (
	.clk          (clk),
	.resetn       (resetn),
	.m_start      (m_start),
	.m_stop       (m_stop),
	.m_mod_remain (m_mod_remain),
	.exe_done     (exe_done),
	.pen          ({pen_d1, pen_d2, pen_d3, pen_d4, pen_d5})
);

//--- bench/pm_tb.sv
`timescale 1ns/1ps

module pm_tb;
	import pm_pkg::*;

	localparam int max_cycles  = 4000;
	// edges from the frame edge to the start pulse
	localparam int img_latency = 6;

	logic              clk = 1'b0;
	logic              resetn;
	logic              cfg_wr;
	reg_addr_t         cfg_addr;
	logic [cfg_dw-1:0] cfg_wdata;
	logic              img_pulse;
	logic              img_valid;
	img_pos_t          img_pos;
	logic              m_state;
	step_t             m_position;
	logic              m_start;
	pm_cmd_t           m_cmd;
	logic              m_stop;
	logic              m_mod_remain;
	step_t             m_new_remain;
	logic              exe_done;

	int       seed = 43242;
	int       n_err = 0;
	int       n_chk = 0;
	int       cycle = 0;
	int       wall_cyc = 0;
	int       n_start = 0;
	int       start_cyc = 0;
	int       frm_cyc = 0;
	int       run_left = 0;
	int       run_len = 10;
	logic     move_back = 1'b0;
	step_t    tbl_model [256];
	step_t    hist_model [4];
	speed_t   cur_speed;
	img_pos_t cur_dst;
	img_pos_t cur_tol;
	frm_t     cur_frm;

	pm_top u_pm_top (
		.clk          (clk),
		.resetn       (resetn),
		.cfg_wr       (cfg_wr),
		.cfg_addr     (cfg_addr),
		.cfg_wdata    (cfg_wdata),
		.img_pulse    (img_pulse),
		.img_valid    (img_valid),
		.img_pos      (img_pos),
		.m_state      (m_state),
		.m_position   (m_position),
		.m_start      (m_start),
		.m_cmd        (m_cmd),
		.m_stop       (m_stop),
		.m_mod_remain (m_mod_remain),
		.m_new_remain (m_new_remain),
		.exe_done     (exe_done)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		wall_cyc++;
		if (wall_cyc >= max_cycles) begin
			$display("run stopped after %0d cycles without finishing", wall_cyc);
			$display("tests failed");
			$finish;
		end
	end

	function automatic int rand_below(int n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic logic [cfg_dw-1:0] ctl_word(logic run, logic single, logic abs_mv,
		logic img);
		ctl_word = '0;
		ctl_word[ctl_run_bit]    = run;
		ctl_word[ctl_single_bit] = single;
		ctl_word[ctl_abs_bit]    = abs_mv;
		ctl_word[ctl_img_bit]    = img;
	endfunction

	// image coordinate beyond the window on the side that matches the direction
	function automatic img_pos_t outside_pos(logic back);
		int off;
		off = cur_tol + 1 + rand_below(200);
		return back ? cur_dst + off : cur_dst - off;
	endfunction

	// one clock, then the motor model reacts
	task automatic tick();
		@(posedge clk);
		#1;
		cycle++;
		if (resetn)
			chk_bit("stop idle", 1'b0, m_stop);
		if (!resetn) begin
			m_state  = 1'b0;
			run_left = 0;
		end else if (run_left > 0) begin
			m_position = move_back ? m_position - 1 : m_position + 1;
			run_left--;
			if (run_left == 0)
				m_state = 1'b0;
		end
		if (m_start) begin
			n_start++;
			start_cyc = cycle;
			run_left  = run_len;
			m_state   = 1'b1;
		end
	endtask

	task automatic chk_step(string name, step_t exp, step_t act);
		n_chk++;
		if (act !== exp) begin
			n_err++;
			$display("FAIL %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic chk_cmd(string name, pm_cmd_t exp, pm_cmd_t act);
		n_chk++;
		if (act !== exp) begin
			n_err++;
			$display("FAIL %s: expected %0d/%0d/%0b, actual %0d/%0d/%0b (speed/step/abs)",
				name, exp.speed, exp.step, exp.abs, act.speed, act.step, act.abs);
		end
	endtask

	task automatic chk_bit(string name, logic exp, logic act);
		n_chk++;
		if (act !== exp) begin
			n_err++;
			$display("FAIL %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic wr_reg(reg_addr_t addr, logic [cfg_dw-1:0] data);
		cfg_wr    = 1'b1;
		cfg_addr  = addr;
		cfg_wdata = data;
		tick();
		cfg_wr = 1'b0;
	endtask

	task automatic load_table();
		step_t val;
		wr_reg(reg_tbl_ptr, 0);
		for (int i = 0; i < 256; i++) begin
			val = 20 + rand_below(180);
			tbl_model[i] = val;
			wr_reg(reg_tbl_data, val);
		end
		repeat (2) tick();
	endtask

	task automatic do_reset();
		resetn     = 1'b0;
		cfg_wr     = 1'b0;
		img_pulse  = 1'b0;
		img_valid  = 1'b0;
		img_pos    = '0;
		m_position = '0;
		repeat (16) tick();
		resetn  = 1'b1;
		n_start = 0;
		for (int i = 0; i < 4; i++)
			hist_model[i] = '0;
		tick();
	endtask

	task automatic send_frame(img_pos_t pos, logic valid);
		img_pulse = 1'b1;
		img_valid = valid;
		img_pos   = pos;
		// history takes the position seen at the frame edge
		for (int i = 3; i > 0; i--)
			hist_model[i] = hist_model[i-1];
		hist_model[0] = m_position;
		tick();
		frm_cyc   = cycle;
		img_pulse = 1'b0;
	endtask

	task automatic wait_start(int limit, string name);
		int guard;
		guard = 0;
		while (n_start == 0 && guard < limit) begin
			tick();
			guard++;
		end
		if (n_start == 0) begin
			n_err++;
			$display("no m_start within %0d cycles in the %s test", limit, name);
		end
	endtask

	task automatic setup_image(logic back);
		cur_dst   = 400 + rand_below(3200);
		cur_tol   = 1 + rand_below(100);
		cur_speed = $random(seed);
		cur_frm   = rand_below(4);
		move_back = back;
		wr_reg(reg_dst, cur_dst);
		wr_reg(reg_tol, cur_tol);
		wr_reg(reg_speed, cur_speed);
		// only the sign of the step sets the direction here
		wr_reg(reg_step, back ? -1 : 1);
		wr_reg(reg_frm, cur_frm);
		wr_reg(reg_ctl, ctl_word(1'b0, 1'b1, 1'b0, 1'b1));
	endtask

	// motor stops, done follows one cycle later and then sticks
	task automatic check_done();
		int   guard;
		logic held;
		guard = 0;
		while (m_state && guard < 100) begin
			tick();
			guard++;
		end
		if (m_state) begin
			n_err++;
			$display("motor model still running after 100 cycles");
		end
		chk_bit("done low at stop", 1'b0, exe_done);
		tick();
		chk_bit("done after stop", 1'b1, exe_done);
		held = 1'b1;
		repeat (30) begin
			tick();
			held = held & exe_done;
		end
		chk_bit("done held", 1'b1, held);
	endtask

	task automatic test_direct();
		pm_cmd_t exp;
		int      wr_cyc;
		do_reset();
		exp.speed = $random(seed);
		exp.step  = $random(seed) % 5000;
		exp.abs   = rand_below(2);
		move_back = exp.step[step_w-1];
		run_len   = 5 + rand_below(30);
		wr_reg(reg_speed, exp.speed);
		wr_reg(reg_step, exp.step);
		wr_reg(reg_ctl, ctl_word(1'b1, 1'b0, exp.abs, 1'b0));
		wr_cyc = cycle;
		wait_start(20, "direct");
		chk_step("direct start delay", 1, start_cyc - wr_cyc);
		chk_cmd("direct command", exp, m_cmd);
		repeat (40) tick();
		chk_step("direct start count", 1, n_start);
	endtask

	task automatic test_inside();
		img_pos_t pos;
		do_reset();
		run_len = 10;
		setup_image(1'b0);
		for (int k = 0; k < 4; k++) begin
			pos = cur_dst - cur_tol + rand_below(2 * cur_tol + 1);
			send_frame(pos, 1'b1);
			repeat (12) tick();
		end
		chk_step("inside start count", 0, n_start);
		chk_bit("inside done", 1'b0, exe_done);
	endtask

	task automatic test_image();
		logic      back;
		img_pos_t  pos;
		tbl_addr_t addr;
		pm_cmd_t   exp;
		do_reset();
		back    = rand_below(2);
		run_len = 5 + rand_below(30);
		setup_image(back);
		pos  = outside_pos(back);
		// pixel error keeps its low bits as the table index
		addr = back ? pos - cur_dst : cur_dst - pos;
		exp.speed = cur_speed;
		exp.step  = tbl_model[addr];
		exp.abs   = 1'b0;
		send_frame(pos, 1'b1);
		wait_start(20, "image");
		chk_step("image start latency", img_latency, start_cyc - frm_cyc);
		chk_cmd("image command", exp, m_cmd);
		check_done();
	endtask

	task automatic test_dynamic();
		img_pos_t  pos;
		tbl_addr_t addr;
		step_t     dst_m;
		step_t     p5;
		logic      short_of;
		do_reset();
		run_len = 400;
		setup_image(1'b0);
		send_frame(outside_pos(1'b0), 1'b0);
		wait_start(20, "dynamic");
		chk_step("dynamic zero step", 0, m_cmd.step);
		for (int k = 0; k < 6; k++) begin
			repeat (4 + rand_below(8)) tick();
			pos  = outside_pos(1'b0);
			addr = cur_dst - pos;
			send_frame(pos, 1'b1);
			// delayed motor position plus the table distance
			dst_m = hist_model[cur_frm] + tbl_model[addr];
			repeat (img_latency - 1) tick();
			p5       = m_position;
			short_of = p5 < dst_m;
			tick();
			chk_bit("dynamic pulse", short_of, m_mod_remain);
			if (short_of)
				chk_step("dynamic remain", dst_m - p5, m_new_remain);
		end
	endtask

	initial begin
		resetn     = 1'b0;
		cfg_wr     = 1'b0;
		cfg_addr   = '0;
		cfg_wdata  = '0;
		img_pulse  = 1'b0;
		img_valid  = 1'b0;
		img_pos    = '0;
		m_state    = 1'b0;
		m_position = '0;
		do_reset();
		load_table();
		repeat (2) test_direct();
		test_inside();
		repeat (3) test_image();
		repeat (2) test_dynamic();
		$display("checks %0d, errors %0d, assertion failures %0d", n_chk, n_err,
			u_pm_top.u_pm_ctl.u_pm_ctl_assert.n_fail);
		if (n_err == 0 && u_pm_top.u_pm_ctl.u_pm_ctl_assert.n_fail == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

//--- flist.f
rtl/pm_pkg.sv
rtl/pm_regs.sv
rtl/pos_delay.sv
rtl/step_table.sv
rtl/pm_ctl.sv
rtl/pm_top.sv
bench/pm_tb_assert.sv
bench/pm_tb.sv
